// File: common/fp_conv_pkg.sv
/*
 * Integer to single-precision conversion definitions.
 * Widths, format constants and the shared types of both stages.
 */

package fp_conv_pkg;

  //////////////////////////////////////////////////
  // widths and format constants
  //////////////////////////////////////////////////

  // integer operand width
  localparam int XLEN = 32;
  // single precision bit pattern
  localparam int FLEN = 32;
  localparam int EXPO_WIDTH = 8;
  // stored fraction, hidden bit excluded
  localparam int FRAC_WIDTH = 23;
  localparam int BIAS = 127;

  //////////////////////////////////////////////////
  // types
  //////////////////////////////////////////////////

  typedef logic [XLEN-1:0] int_data_t;
  typedef logic [FLEN-1:0] fp_data_t;

  // leading zero count, 0 up to 32
  typedef logic [5:0] shift_amt_t;

  // biased exponent field
  typedef logic [EXPO_WIDTH-1:0] expo_t;

  // request tag, returned with the result
  typedef logic [3:0] id_t;

  // riscv order: NV DZ OF UF NX, bit 0 is inexact
  typedef logic [4:0] fflags_t;

  // riscv rounding modes, 5 to 7 not used here
  typedef enum logic [2:0] {
    RNE = 3'd0,
    RTZ = 3'd1,
    RDN = 3'd2,
    RUP = 3'd3,
    RMM = 3'd4
  } rounding_mode_t;

endpackage

// File: hdl/clz.sv
/*
 * Leading zero counter for a 32-bit word.
 * Binary tree of pairwise merges, all-zero input gives 32.
 */

module clz (
  input fp_conv_pkg::int_data_t in,
  output fp_conv_pkg::shift_amt_t count
);
  import fp_conv_pkg::*;

  // tree[l][j] is the count of group j at level l
  // a group at level l covers 2**l bits, higher j is more significant
  // value 2**l marks an all-zero group
  shift_amt_t tree [0:5][0:31];

  always_comb begin
    // unused slots of the upper levels
    for (int l = 0; l < 6; l++) begin
      for (int j = 0; j < 32; j++) begin
        tree[l][j] = '0;
      end
    end

    // leaves, one bit each
    for (int i = 0; i < XLEN; i++) begin
      tree[0][i] = {5'b0, ~in[i]};
    end

    // merge pairs
    // upper half all zero, so add in the lower count
    // otherwise the upper count stands
    for (int l = 0; l < 5; l++) begin
      for (int j = 0; j < (16 >> l); j++) begin
        if (tree[l][2*j+1][l])
          tree[l+1][j] = tree[l][2*j+1] + tree[l][2*j];
        else
          tree[l+1][j] = tree[l][2*j+1];
      end
    end
  end

  // root of the tree
  assign count = tree[5][0];

endmodule

// File: fp_i2f/fp_i2f.sv
/*
 * Integer to float, first stage.
 * Sign, absolute value and zero detect, stage register, then
 * leading zero count on the registered magnitude.
 */

module fp_i2f (
  input logic clk,
  input logic reset,
  input logic advance,

  // request
  input logic new_request,
  input fp_conv_pkg::id_t id,
  input fp_conv_pkg::int_data_t rs1,
  input logic is_signed,
  input fp_conv_pkg::rounding_mode_t rm,

  // to the normalize and round stage
  output logic s1_done,
  output fp_conv_pkg::id_t s1_id,
  output fp_conv_pkg::rounding_mode_t s1_rm,
  output logic s1_sign,
  output logic s1_zero,
  output fp_conv_pkg::int_data_t s1_magnitude,
  output fp_conv_pkg::shift_amt_t s1_clz
);
  import fp_conv_pkg::*;

  logic sign_in;
  logic zero_in;
  int_data_t neg_rs1;
  int_data_t abs_rs1;

  //////////////////////////////////////////////////
  // absolute value
  //////////////////////////////////////////////////

  // negative only for signed requests with msb set
  assign sign_in = is_signed & rs1[XLEN-1];
  assign neg_rs1 = -rs1;

  // most negative signed value negates onto itself
  // which is still the right unsigned magnitude
  assign abs_rs1 = sign_in ? neg_rs1 : rs1;

  assign zero_in = ~|rs1;

  //////////////////////////////////////////////////
  // stage register
  //////////////////////////////////////////////////

  // request strobe
  always_ff @(posedge clk) begin
    if (reset)
      s1_done <= 1'b0;
    else if (advance)
      s1_done <= new_request;
  end

  // payload, held while advance is low
  always_ff @(posedge clk) begin
    if (advance) begin
      s1_id <= id;
      s1_rm <= rm;
      s1_sign <= sign_in;
      s1_zero <= zero_in;
      s1_magnitude <= abs_rs1;
    end
  end

  //////////////////////////////////////////////////
  // leading zeros
  //////////////////////////////////////////////////

  // count in the back half of the stage
  clz u_clz (
    .in(s1_magnitude),
    .count(s1_clz)
  );

  // only the five defined modes are issued
  rm_legal: assert property (
    @(posedge clk) disable iff (reset)
    (new_request && advance) |-> (rm <= RMM)
  );

endmodule

// File: fp_i2f/fp_normalize_round.sv
/*
 * Integer to float, second stage.
 * Normalizes the magnitude, rounds in the riscv modes,
 * assembles the float and registers the writeback outputs.
 */

module fp_normalize_round (
  input logic clk,
  input logic reset,
  input logic advance,

  // from the first stage
  input logic s1_done,
  input fp_conv_pkg::id_t s1_id,
  input fp_conv_pkg::rounding_mode_t s1_rm,
  input logic s1_sign,
  input logic s1_zero,
  input fp_conv_pkg::int_data_t s1_magnitude,
  input fp_conv_pkg::shift_amt_t s1_clz,

  // writeback
  output logic done,
  output fp_conv_pkg::id_t id_out,
  output fp_conv_pkg::fp_data_t rd,
  output fp_conv_pkg::fflags_t fflags
);
  import fp_conv_pkg::*;

  int_data_t shifted;
  logic [FRAC_WIDTH-1:0] frac;
  logic guard_bit;
  logic round_bit;
  logic sticky_bit;
  logic inexact;
  logic round_up;
  expo_t expo;
  logic [FRAC_WIDTH:0] frac_rounded;
  expo_t expo_rounded;
  fp_data_t result;
  fflags_t result_flags;

  //////////////////////////////////////////////////
  // normalize
  //////////////////////////////////////////////////

  // leading one lands in the msb, zero input stays zero
  assign shifted = s1_magnitude << s1_clz;

  // msb is the hidden bit
  assign frac = shifted[XLEN-2 -: FRAC_WIDTH];
  assign guard_bit = shifted[XLEN-2-FRAC_WIDTH];
  assign round_bit = shifted[XLEN-3-FRAC_WIDTH];
  assign sticky_bit = |shifted[XLEN-4-FRAC_WIDTH:0];

  // position of the leading one plus bias
  assign expo = expo_t'(BIAS + XLEN - 1) - expo_t'(s1_clz);

  assign inexact = guard_bit | round_bit | sticky_bit;

  //////////////////////////////////////////////////
  // round
  //////////////////////////////////////////////////

  always_comb begin
    unique case (s1_rm)
      // ties to even
      RNE: round_up = guard_bit & (round_bit | sticky_bit | frac[0]);
      // truncate
      RTZ: round_up = 1'b0;
      // toward minus infinity, grows negatives only
      RDN: round_up = s1_sign & inexact;
      // toward plus infinity
      RUP: round_up = ~s1_sign & inexact;
      // ties away from zero
      RMM: round_up = guard_bit;
      default: round_up = 1'b0;
    endcase
  end

  // extra bit catches the carry out of the fraction
  assign frac_rounded = {1'b0, frac} + (FRAC_WIDTH+1)'(round_up);

  // on carry the fraction bits are already all zero
  // largest exponent here is 159, no overflow possible
  assign expo_rounded = expo + expo_t'(frac_rounded[FRAC_WIDTH]);

  //////////////////////////////////////////////////
  // assemble
  //////////////////////////////////////////////////

  // zero gives +0 with no flags
  assign result = s1_zero ? '0 :
    {s1_sign, expo_rounded, frac_rounded[FRAC_WIDTH-1:0]};

  // inexact only, nothing else can be raised
  assign result_flags = s1_zero ? '0 : {4'b0, inexact};

  //////////////////////////////////////////////////
  // output register
  //////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (reset)
      done <= 1'b0;
    else if (advance)
      done <= s1_done;
  end

  always_ff @(posedge clk) begin
    if (advance) begin
      id_out <= s1_id;
      rd <= result;
      fflags <= result_flags;
    end
  end

  // zero flag and magnitude come from the same first stage operand
  zero_consistent: assert property (
    @(posedge clk) disable iff (reset)
    s1_done |-> !(s1_zero && (s1_magnitude != '0))
  );

endmodule

// File: hdl/int_to_fp_unit.sv
/*
 * Integer to single-precision conversion unit.
 * Two stages under one advance, latency of two advancing edges.
 */

module int_to_fp_unit (
  input logic clk,
  input logic reset,
  input logic advance,

  // request
  input logic new_request,
  input fp_conv_pkg::id_t id,
  input fp_conv_pkg::int_data_t rs1,
  input logic is_signed,
  input fp_conv_pkg::rounding_mode_t rm,

  // result
  output logic done,
  output fp_conv_pkg::id_t id_out,
  output fp_conv_pkg::fp_data_t rd,
  output fp_conv_pkg::fflags_t fflags
);
  import fp_conv_pkg::*;

  // between the stages
  logic s1_done;
  id_t s1_id;
  rounding_mode_t s1_rm;
  logic s1_sign;
  logic s1_zero;
  int_data_t s1_magnitude;
  shift_amt_t s1_clz;

  //////////////////////////////////////////////////
  // sign, magnitude and leading zeros
  //////////////////////////////////////////////////

  fp_i2f u_fp_i2f (
    .clk(clk),
    .reset(reset),
    .advance(advance),
    .new_request(new_request),
    .id(id),
    .rs1(rs1),
    .is_signed(is_signed),
    .rm(rm),
    .s1_done(s1_done),
    .s1_id(s1_id),
    .s1_rm(s1_rm),
    .s1_sign(s1_sign),
    .s1_zero(s1_zero),
    .s1_magnitude(s1_magnitude),
    .s1_clz(s1_clz)
  );

  //////////////////////////////////////////////////
  // normalize, round and writeback
  //////////////////////////////////////////////////

  fp_normalize_round u_fp_normalize_round (
    .clk(clk),
    .reset(reset),
    .advance(advance),
    .s1_done(s1_done),
    .s1_id(s1_id),
    .s1_rm(s1_rm),
    .s1_sign(s1_sign),
    .s1_zero(s1_zero),
    .s1_magnitude(s1_magnitude),
    .s1_clz(s1_clz),
    .done(done),
    .id_out(id_out),
    .rd(rd),
    .fflags(fflags)
  );

endmodule

// File: testbench/tb_int_to_fp_unit.sv
/*
 * Testbench for the integer to single-precision unit.
 * Directed and random requests under random stalls, scoreboard
 * against a whole-integer reference model.
 */

module tb_int_to_fp_unit;
  import fp_conv_pkg::*;

  //////////////////////////////////////////////////
  // run length
  //////////////////////////////////////////////////

  localparam int RESET_CYCLES = 2;
  localparam int SETTLE_CYCLES = 2;
  localparam int DRIVE_DELAY = 5;
  // zero, exact, rounding values x modes x forms, boundaries
  localparam int N_DIRECTED = 2 + 6 + 7 * 5 * 3 + 3 * 5;
  localparam int N_RANDOM = 400;
  localparam int MAX_GAP = 2;
  localparam int MAX_STALL = 2;
  localparam int DRAIN_CYCLES = 4;
  localparam int STIM_CYCLES = RESET_CYCLES + SETTLE_CYCLES + 2 + N_DIRECTED +
    N_RANDOM * (MAX_GAP + MAX_STALL + 1) + DRAIN_CYCLES;
  localparam int TIMEOUT_CYCLES = 2 * STIM_CYCLES + 50;

  logic clk = 1'b0;
  logic reset;
  logic advance;
  logic new_request;
  id_t id;
  int_data_t rs1;
  logic is_signed;
  rounding_mode_t rm;
  logic done;
  id_t id_out;
  fp_data_t rd;
  fflags_t fflags;

  // scoreboard, oldest request at the front
  id_t exp_id_q[$];
  fp_data_t exp_rd_q[$];
  fflags_t exp_flags_q[$];

  id_t next_id = '0;
  int unsigned lcg_state = 34;
  int cycle_count = 0;

  int_to_fp_unit DUT (
    .clk(clk),
    .reset(reset),
    .advance(advance),
    .new_request(new_request),
    .id(id),
    .rs1(rs1),
    .is_signed(is_signed),
    .rm(rm),
    .done(done),
    .id_out(id_out),
    .rd(rd),
    .fflags(fflags)
  );

  always #50 clk = ~clk;

  //////////////////////////////////////////////////
  // failure handling and compares
  //////////////////////////////////////////////////

  task automatic stop_on_error();
    $display("FAIL: see errors above");
    $fatal(1, "simulation stopped at the first error");
  endtask

  task automatic check_fp(input string name, input fp_data_t expected, input fp_data_t actual);
    if (actual !== expected) begin
      $display("Mismatch at time %0t: %s expected %h actual %h",
        $time, name, expected, actual);
      stop_on_error();
    end
  endtask

  task automatic check_flags(input string name, input fflags_t expected,
    input fflags_t actual);
    if (actual !== expected) begin
      $display("Mismatch at time %0t: %s expected %b actual %b",
        $time, name, expected, actual);
      stop_on_error();
    end
  endtask

  task automatic check_id(input string name, input id_t expected, input id_t actual);
    if (actual !== expected) begin
      $display("Mismatch at time %0t: %s expected %h actual %h",
        $time, name, expected, actual);
      stop_on_error();
    end
  endtask

  task automatic check_done(input string name, input logic expected, input logic actual);
    if (actual !== expected) begin
      $display("Mismatch at time %0t: %s expected %b actual %b",
        $time, name, expected, actual);
      stop_on_error();
    end
  endtask

  //////////////////////////////////////////////////
  // reference model and random numbers
  //////////////////////////////////////////////////

  // exact value split into a 24-bit significand and a remainder
  function automatic void ref_i2f(input int_data_t value, input logic sgn,
    input rounding_mode_t mode, output fp_data_t exp_rd, output fflags_t exp_flags);
    logic neg;
    logic [63:0] mag;
    logic [63:0] mant;
    logic [63:0] rem;
    logic [63:0] half;
    int top;
    int sh;
    logic inexact;
    logic up;
    neg = sgn & value[31];
    if (neg)
      mag = 64'h1_0000_0000 - {32'b0, value};
    else
      mag = {32'b0, value};
    exp_rd = '0;
    exp_flags = '0;
    if (mag == 64'd0)
      return;
    // position of the leading one
    top = 0;
    for (int b = 0; b < 64; b++) begin
      if (mag[b])
        top = b;
    end
    if (top > 23) begin
      sh = top - 23;
      mant = mag >> sh;
      rem = mag - (mant << sh);
      // half of one unit in the last place
      half = 64'd1 << (sh - 1);
    end else begin
      mant = mag << (23 - top);
      rem = 64'd0;
      half = 64'd0;
    end
    inexact = (rem != 64'd0);
    case (mode)
      RNE: up = inexact && ((rem > half) || ((rem == half) && mant[0]));
      RTZ: up = 1'b0;
      RDN: up = inexact && neg;
      RUP: up = inexact && !neg;
      RMM: up = inexact && (rem >= half);
      default: up = 1'b0;
    endcase
    mant = mant + {63'd0, up};
    // rounded up to the next power of two
    if (mant[24]) begin
      mant = mant >> 1;
      top = top + 1;
    end
    exp_rd = {neg, expo_t'(top + BIAS), mant[22:0]};
    exp_flags = {4'b0, inexact};
  endfunction

  // upper half of the lcg state, low bits are weak
  function automatic int unsigned next_random();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state >> 16;
  endfunction

  //////////////////////////////////////////////////
  // stimulus tasks
  //////////////////////////////////////////////////

  task automatic drive(input logic adv, input logic req, input id_t req_id,
    input int_data_t value, input logic sgn, input rounding_mode_t mode);
    @(posedge clk);
    #DRIVE_DELAY;
    advance = adv;
    new_request = req;
    id = req_id;
    rs1 = value;
    is_signed = sgn;
    rm = mode;
  endtask

  // one request, accepted on the next edge
  task automatic issue(input int_data_t value, input logic sgn, input rounding_mode_t mode);
    drive(1'b1, 1'b1, next_id, value, sgn, mode);
    next_id = next_id + 4'd1;
  endtask

  task automatic run_directed();
    int_data_t ties [0:6];
    // ties, just below and just above, odd and even significands
    ties = '{32'h0100_0001, 32'h0100_0003, 32'h0400_0001, 32'h0400_0004,
      32'h0400_0005, 32'h0400_000C, 32'h7FFF_FFC0};
    // zero
    issue(32'h0, 1'b0, RNE);
    issue(32'h0, 1'b1, RDN);
    // exact
    issue(32'h1, 1'b0, RNE);
    issue(32'h1, 1'b1, RUP);
    issue(32'hFFFF_FFFF, 1'b1, RNE);
    issue(32'h00FF_FFFF, 1'b0, RTZ);
    issue(32'h00FF_FFFF, 1'b1, RMM);
    issue(32'hFF80_0000, 1'b1, RDN);
    // rounding in every mode, unsigned, signed and negated
    for (int i = 0; i < 7; i++) begin
      for (int m = 0; m < 5; m++) begin
        issue(ties[i], 1'b0, rounding_mode_t'(m[2:0]));
        issue(ties[i], 1'b1, rounding_mode_t'(m[2:0]));
        issue(-ties[i], 1'b1, rounding_mode_t'(m[2:0]));
      end
    end
    // boundaries
    for (int m = 0; m < 5; m++) begin
      issue(32'h8000_0000, 1'b1, rounding_mode_t'(m[2:0]));
      issue(32'hFFFF_FFFF, 1'b0, rounding_mode_t'(m[2:0]));
      issue(32'h7FFF_FFFF, 1'b1, rounding_mode_t'(m[2:0]));
    end
  endtask

  // idle gaps with random advance, then a request held through stalls
  task automatic run_random();
    int unsigned gap;
    int unsigned stall;
    int unsigned hi;
    int unsigned lo;
    int unsigned pick;
    int_data_t value;
    logic sgn;
    rounding_mode_t mode;
    for (int n = 0; n < N_RANDOM; n++) begin
      gap = next_random() % (MAX_GAP + 1);
      stall = next_random() % (MAX_STALL + 1);
      hi = next_random();
      lo = next_random();
      pick = next_random();
      value = {hi[15:0], lo[15:0]} >> pick[4:0];
      // inverted small values give small negative numbers
      if (pick[5])
        value = ~value;
      sgn = pick[6];
      pick = next_random() % 5;
      mode = rounding_mode_t'(pick[2:0]);
      repeat (gap) begin
        pick = next_random();
        drive(pick[0], 1'b0, next_id, value, sgn, mode);
      end
      repeat (stall)
        drive(1'b0, 1'b1, next_id, value, sgn, mode);
      issue(value, sgn, mode);
    end
  endtask

  //////////////////////////////////////////////////
  // scoreboard, sampled mid cycle
  //////////////////////////////////////////////////

  always @(negedge clk) begin : scoreboard
    id_t exp_id;
    fp_data_t exp_rd;
    fflags_t exp_flags;
    fp_data_t new_rd;
    fflags_t new_flags;
    if (!reset) begin
      if ($isunknown(done)) begin
        $display("Error: done is unknown at time %0t", $time);
        stop_on_error();
      end
      // result consumed on the coming edge
      if (done && advance) begin
        if (exp_id_q.size() == 0) begin
          $display("Error: done is high at time %0t but no result is expected", $time);
          stop_on_error();
        end else begin
          exp_id = exp_id_q.pop_front();
          exp_rd = exp_rd_q.pop_front();
          exp_flags = exp_flags_q.pop_front();
          check_id("id_out", exp_id, id_out);
          check_fp("rd", exp_rd, rd);
          check_flags("fflags", exp_flags, fflags);
        end
      end
      // request accepted on the coming edge
      if (new_request && advance) begin
        ref_i2f(rs1, is_signed, rm, new_rd, new_flags);
        exp_id_q.push_back(id);
        exp_rd_q.push_back(new_rd);
        exp_flags_q.push_back(new_flags);
      end
    end
  end

  always @(posedge clk) begin
    cycle_count = cycle_count + 1;
    if (cycle_count >= TIMEOUT_CYCLES) begin
      $display("Error: timeout after %0d cycles", cycle_count);
      stop_on_error();
    end
  end

  //////////////////////////////////////////////////
  // main sequence
  //////////////////////////////////////////////////

  initial begin
    reset = 1'b1;
    advance = 1'b0;
    new_request = 1'b0;
    id = '0;
    rs1 = '0;
    is_signed = 1'b0;
    rm = RNE;
    repeat (RESET_CYCLES) @(posedge clk);
    #DRIVE_DELAY;
    reset = 1'b0;
    @(negedge clk);
    check_done("done", 1'b0, done);
    // advancing with no requests, done must stay low
    repeat (SETTLE_CYCLES)
      drive(1'b1, 1'b0, next_id, '0, 1'b0, RNE);
    run_directed();
    run_random();
    // latency is two advancing edges
    repeat (DRAIN_CYCLES)
      drive(1'b1, 1'b0, next_id, '0, 1'b0, RNE);
    @(posedge clk);
    #1;
    if (exp_id_q.size() != 0) begin
      $display("Error: %0d results were never delivered", exp_id_q.size());
      stop_on_error();
    end else begin
      $display("PASS: all tests");
      $finish;
    end
  end

endmodule

// File: flist.f
common/fp_conv_pkg.sv
hdl/clz.sv
fp_i2f/fp_i2f.sv
fp_i2f/fp_normalize_round.sv
hdl/int_to_fp_unit.sv
testbench/tb_int_to_fp_unit.sv

// File: run_sim.sh
#!/bin/sh
# Build and run the integer to float testbench with Verilator.
# The exit status is the simulator's: nonzero on any failure.

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert \
  --top-module tb_int_to_fp_unit \
  -f flist.f \
  -o sim_tb
status=$?
if [ $status -ne 0 ]; then
  echo "verilator build failed"
  exit $status
fi

./obj_dir/sim_tb
status=$?
if [ $status -ne 0 ]; then
  echo "simulation failed"
  exit $status
fi

exit 0
